// File: dv/exec_flags_unit_tb.sv
// Testbench for the INC/SAL/SAR execute slice with EFLAGS merge
// Seeded random requests are checked against a flag and merge model kept here

`timescale 1ns/1ns

module exec_flags_unit_tb;

	// CF and DF start set so that held and cleared flags both show up
	localparam x86_exec_pkg::word_t RESET_EFLAGS = 32'h0000_0403;
	localparam int NUM_REQ = 200;
	// About 1220 cycles of traffic plus margin
	localparam int TIMEOUT_CYCLES = 1600;

	logic                    clk;
	logic                    rst_n;
	logic                    in_valid;
	x86_exec_pkg::exec_req_t req;
	logic                    out_valid;
	x86_exec_pkg::exec_rsp_t rsp;

	integer seed;
	int     check_count;
	int     error_count;
	int     cycle_count;

	// Model state, EFLAGS copy and responses still owed by the DUT
	x86_exec_pkg::word_t     model_eflags;
	logic                    pending;
	x86_exec_pkg::exec_rsp_t exp_q[$];

	exec_flags_unit #(
		.RESET_EFLAGS (RESET_EFLAGS)
	) exec_flags_unit_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.req       (req),
		.out_valid (out_valid),
		.rsp       (rsp)
	);

	// 40 ns clock
	always #20 clk = ~clk;

	// --------------------
	// Reference model
	// --------------------

	function automatic x86_exec_pkg::word_t model_result(input x86_exec_pkg::exec_op_t op,
		input x86_exec_pkg::word_t a, input logic [4:0] n);
		x86_exec_pkg::word_t r;
		case (op)
			x86_exec_pkg::OP_SAL: r = a << n;
			x86_exec_pkg::OP_SAR: r = $signed(a) >>> n;
			default:              r = a + 32'd1;
		endcase
		return r;
	endfunction

	function automatic x86_exec_pkg::flag_bits_t model_flags(input x86_exec_pkg::exec_op_t op,
		input x86_exec_pkg::word_t a, input logic [4:0] n, input x86_exec_pkg::word_t r);
		x86_exec_pkg::flag_bits_t f;
		int ones;
		int idx;
		f = '0;
		ones = 0;
		for (int i = 0; i < 8; i++) begin
			ones = ones + int'(r[i]);
		end
		f.pf = (ones % 2 == 0);
		f.zf = (r == 32'd0);
		f.sf = r[31];
		// DF stays 0, CF and AF default to 0
		case (op)
			x86_exec_pkg::OP_SAL: begin
				idx = 32 - int'(n);
				if (n != 5'd0) f.cf = a[idx];
				f.of = a[31] ^ r[31];
			end
			x86_exec_pkg::OP_SAR: begin
				idx = int'(n) - 1;
				if (n != 5'd0) f.cf = a[idx];
			end
			default: begin
				f.of = !a[31] && r[31];
				f.af = (a[3:0] == 4'hF);
			end
		endcase
		return f;
	endfunction

	// Masked flags overwrite their EFLAGS bits, everything else is held
	function automatic x86_exec_pkg::word_t model_merge(input x86_exec_pkg::word_t old,
		input x86_exec_pkg::flag_bits_t f, input x86_exec_pkg::flag_bits_t m);
		x86_exec_pkg::word_t e;
		e = old;
		if (m.cf) e[x86_exec_pkg::CF_BIT] = f.cf;
		if (m.pf) e[x86_exec_pkg::PF_BIT] = f.pf;
		if (m.af) e[x86_exec_pkg::AF_BIT] = f.af;
		if (m.zf) e[x86_exec_pkg::ZF_BIT] = f.zf;
		if (m.sf) e[x86_exec_pkg::SF_BIT] = f.sf;
		if (m.df) e[x86_exec_pkg::DF_BIT] = f.df;
		if (m.of) e[x86_exec_pkg::OF_BIT] = f.of;
		e[1] = 1'b1;
		return e;
	endfunction

	// --------------------
	// Checking and driving
	// --------------------

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// Outputs here belong to the strobe of the previous cycle
	task automatic check_outputs();
		x86_exec_pkg::exec_rsp_t exp;
		compare("out_valid", {31'b0, out_valid}, {31'b0, pending});
		if (pending) begin
			exp = exp_q.pop_front();
			compare("rsp.result", rsp.result, exp.result);
			compare("rsp.eflags", rsp.eflags, exp.eflags);
		end else begin
			// Idle cycle, EFLAGS must hold
			compare("rsp.eflags", rsp.eflags, model_eflags);
		end
	endtask

	// One cycle: check last response, then drive 2 ns after the edge
	task automatic step(input logic valid, input x86_exec_pkg::exec_req_t r);
		x86_exec_pkg::flag_bits_t f;
		x86_exec_pkg::exec_rsp_t exp;
		@(posedge clk);
		#2;
		check_outputs();
		in_valid = valid;
		req = r;
		if (valid) begin
			exp.result = model_result(r.op, r.a, r.b[4:0]);
			f = model_flags(r.op, r.a, r.b[4:0], exp.result);
			model_eflags = model_merge(model_eflags, f, r.flag_mask);
			exp.eflags = model_eflags;
			exp_q.push_back(exp);
		end
		pending = valid;
	endtask

	// Operand, op and mask choice per test
	task automatic build_req(input int test_id, output x86_exec_pkg::exec_req_t r);
		x86_exec_pkg::word_t x;
		int sel;
		r.a = $random(seed);
		r.b = $random(seed);
		x = $random(seed);
		sel = int'(x[9:8]);
		case (test_id)
			1: begin
				r.op = x86_exec_pkg::OP_INC;
				r.flag_mask = '0;
			end
			2: begin
				r.op = x86_exec_pkg::OP_INC;
				// OF, SF, ZF, AF, PF
				r.flag_mask = 7'b1011110;
				if (sel == 0) r.a = 32'hFFFF_FFFF;
				if (sel == 1) r.a = 32'h7FFF_FFFF;
				if (sel == 2) r.a = r.a | 32'h0000_000F;
			end
			3: begin
				r.op = x86_exec_pkg::OP_SAL;
				r.flag_mask = 7'h7F;
			end
			4: begin
				r.op = x86_exec_pkg::OP_SAR;
				r.flag_mask = 7'h7F;
				if (x[12]) r.a[31] = 1'b1;
			end
			default: begin
				sel = int'(x[17:16]);
				case (sel)
					0:       r.op = x86_exec_pkg::OP_INC;
					1:       r.op = x86_exec_pkg::OP_SAL;
					default: r.op = x86_exec_pkg::OP_SAR;
				endcase
				r.flag_mask = x[6:0];
			end
		endcase
	endtask

	// Random payload with every flag selected, held while in_valid is low
	task automatic build_idle_req(output x86_exec_pkg::exec_req_t r);
		x86_exec_pkg::word_t x;
		r.a = $random(seed);
		r.b = $random(seed);
		x = $random(seed);
		r.op = x[0] ? x86_exec_pkg::OP_SAL : x86_exec_pkg::OP_INC;
		r.flag_mask = 7'h7F;
	endtask

	// Idle gap chance is 1 in (idle_mask + 1)
	task automatic run_test(input int test_id, input string name, input int count,
		input logic [31:0] idle_mask);
		x86_exec_pkg::exec_req_t r;
		x86_exec_pkg::exec_req_t idle_r;
		logic [31:0] x;
		int errs_before;
		errs_before = error_count;
		for (int i = 0; i < count; i++) begin
			x = $random(seed);
			if ((x & idle_mask) == 32'd0) begin
				build_idle_req(idle_r);
				step(1'b0, idle_r);
			end
			build_req(test_id, r);
			step(1'b1, r);
		end
		// Drain the last response
		build_idle_req(idle_r);
		step(1'b0, idle_r);
		$display("Test %0d %s: %0d requests, %0d errors", test_id, name, count,
			error_count - errs_before);
	endtask

	// --------------------
	// Sequence
	// --------------------

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		req = '0;
		seed = 32'h368b07d8;
		check_count = 0;
		error_count = 0;
		model_eflags = RESET_EFLAGS;
		pending = 1'b0;
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;
		run_test(1, "reset value", 1, 32'h7);
		run_test(2, "INC", NUM_REQ, 32'h7);
		run_test(3, "SAL", NUM_REQ, 32'h7);
		run_test(4, "SAR", NUM_REQ, 32'h7);
		run_test(5, "partial masks", NUM_REQ, 32'h7);
		run_test(6, "back-to-back", NUM_REQ, 32'h1);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	// Watchdog
	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Run timed out after %0d cycles", cycle_count);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the exec_flags_unit testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=exec_flags_unit_sim
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f \
	--top-module exec_flags_unit_tb \
	--Mdir "$BUILD_DIR" \
	-o "$SIM_BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF '*** PASSED ***' "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

// File: sim.f
source/x86_exec_pkg.sv
source/flag_logic.sv
source/inc_by_1_w_flags.sv
source/shift_arith_left_w_flags.sv
source/shift_arith_right_w_flags.sv
source/eflags_merge.sv
source/exec_flags_unit.sv
dv/exec_flags_unit_tb.sv

// File: source/eflags_merge.sv
// Architectural EFLAGS register with a per-flag overwrite mask
// Masked flags are scattered into their bit positions, the rest keep old values

`timescale 1ns/1ns

module eflags_merge #(
	parameter x86_exec_pkg::word_t RESET_EFLAGS = 32'd1 << x86_exec_pkg::EFLAGS_FIXED_ONE
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     update,
	input  x86_exec_pkg::flag_bits_t new_flags,
	input  x86_exec_pkg::flag_bits_t flag_mask,
	output x86_exec_pkg::word_t      eflags
);

	// Current and next EFLAGS value
	x86_exec_pkg::word_t eflags_q;
	x86_exec_pkg::word_t eflags_d;

	// Take the new bit where the mask is set, else hold the old one
	function automatic logic pick(input logic sel, input logic new_bit, input logic old_bit);
		pick = sel ? new_bit : old_bit;
	endfunction

	// --------------------
	// Merge
	// --------------------

	always_comb begin
		// Undefined bits read 0
		eflags_d = '0;
		eflags_d[x86_exec_pkg::EFLAGS_FIXED_ONE] = 1'b1;

		eflags_d[x86_exec_pkg::CF_BIT] =
			pick(flag_mask.cf, new_flags.cf, eflags_q[x86_exec_pkg::CF_BIT]);
		eflags_d[x86_exec_pkg::PF_BIT] =
			pick(flag_mask.pf, new_flags.pf, eflags_q[x86_exec_pkg::PF_BIT]);
		eflags_d[x86_exec_pkg::AF_BIT] =
			pick(flag_mask.af, new_flags.af, eflags_q[x86_exec_pkg::AF_BIT]);
		eflags_d[x86_exec_pkg::ZF_BIT] =
			pick(flag_mask.zf, new_flags.zf, eflags_q[x86_exec_pkg::ZF_BIT]);
		eflags_d[x86_exec_pkg::SF_BIT] =
			pick(flag_mask.sf, new_flags.sf, eflags_q[x86_exec_pkg::SF_BIT]);
		eflags_d[x86_exec_pkg::DF_BIT] =
			pick(flag_mask.df, new_flags.df, eflags_q[x86_exec_pkg::DF_BIT]);
		eflags_d[x86_exec_pkg::OF_BIT] =
			pick(flag_mask.of, new_flags.of, eflags_q[x86_exec_pkg::OF_BIT]);
	end

	// Register only moves on an issued operation
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			eflags_q <= RESET_EFLAGS;
		end else if (update) begin
			eflags_q <= eflags_d;
		end
	end

	assign eflags = eflags_q;

	// Reserved bit 1 holds across reset release and every later update
	a_fixed_one: assert property (
		@(posedge clk) rst_n |-> eflags_q[x86_exec_pkg::EFLAGS_FIXED_ONE]
	);

endmodule

// File: source/exec_flags_unit.sv
// Execute-stage slice with INC, SAL and SAR plus EFLAGS merge
// One request per in_valid strobe, result and EFLAGS appear one cycle later

`timescale 1ns/1ns

module exec_flags_unit #(
	parameter x86_exec_pkg::word_t RESET_EFLAGS = 32'd1 << x86_exec_pkg::EFLAGS_FIXED_ONE
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    in_valid,
	input  x86_exec_pkg::exec_req_t req,
	output logic                    out_valid,
	output x86_exec_pkg::exec_rsp_t rsp
);

	// Per-unit results and flags
	x86_exec_pkg::word_t      inc_result;
	x86_exec_pkg::flag_bits_t inc_flags;
	x86_exec_pkg::word_t      sal_result;
	x86_exec_pkg::flag_bits_t sal_flags;
	x86_exec_pkg::word_t      sar_result;
	x86_exec_pkg::flag_bits_t sar_flags;

	// Unit picked by the op code
	x86_exec_pkg::word_t      sel_result;
	x86_exec_pkg::flag_bits_t sel_flags;

	// Registered result and strobe
	x86_exec_pkg::word_t result_q;
	logic                valid_q;

	// EFLAGS straight from the merge register
	x86_exec_pkg::word_t merged_eflags;

	// --------------------
	// Functional units
	// --------------------

	// Operands fan out to all three units in parallel
	inc_by_1_w_flags inc_by_1_w_flags_inst (
		.a         (req.a),
		.sum       (inc_result),
		.carry_out (),
		.flags     (inc_flags)
	);

	// Shift count is the low 5 bits of b
	shift_arith_left_w_flags shift_arith_left_w_flags_inst (
		.a          (req.a),
		.count      (req.b[4:0]),
		.sal_result (sal_result),
		.carry_out  (),
		.flags      (sal_flags)
	);

	shift_arith_right_w_flags shift_arith_right_w_flags_inst (
		.a          (req.a),
		.count      (req.b[4:0]),
		.sar_result (sar_result),
		.carry_out  (),
		.flags      (sar_flags)
	);

	// Result and flag mux
	always_comb begin
		case (req.op)
			x86_exec_pkg::OP_SAL: begin
				sel_result = sal_result;
				sel_flags  = sal_flags;
			end
			x86_exec_pkg::OP_SAR: begin
				sel_result = sar_result;
				sel_flags  = sar_flags;
			end
			default: begin
				sel_result = inc_result;
				sel_flags  = inc_flags;
			end
		endcase
	end

	// --------------------
	// Flag merge and output stage
	// --------------------

	// EFLAGS updates on the same edge as the result register
	eflags_merge #(
		.RESET_EFLAGS (RESET_EFLAGS)
	) eflags_merge_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.update    (in_valid),
		.new_flags (sel_flags),
		.flag_mask (req.flag_mask),
		.eflags    (merged_eflags)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= in_valid;
		end
	end

	// Result payload captured on each strobe
	always_ff @(posedge clk) begin
		if (in_valid) begin
			result_q <= sel_result;
		end
	end

	assign out_valid = valid_q;

	always_comb begin
		rsp.result = result_q;
		rsp.eflags = merged_eflags;
	end

	// Decode never issues an encoding outside the three units
	a_legal_op: assert property (
		@(posedge clk) disable iff (!rst_n)
		in_valid |-> (req.op inside {x86_exec_pkg::OP_INC, x86_exec_pkg::OP_SAL,
			x86_exec_pkg::OP_SAR})
	);

	// Fixed one-cycle latency, no bubbles and no extra strobes
	a_valid_follows: assert property (
		@(posedge clk) disable iff (!rst_n)
		in_valid |=> out_valid
	);

	a_no_spurious_valid: assert property (
		@(posedge clk) disable iff (!rst_n)
		!in_valid |=> !out_valid
	);

endmodule

// File: source/flag_logic.sv
// Common status flag logic for the flag-producing units
// Derives OF, SF, ZF and PF from a result and passes CF and AF through
// Output ordering matches the EFLAGS bit order from OF down to CF

`timescale 1ns/1ns

module flag_logic (
	input  x86_exec_pkg::word_t      result,
	input  logic                     a_sign,
	input  logic                     carry,
	input  logic                     aux,
	input  logic                     of_sel,
	input  logic                     carry_en,
	output x86_exec_pkg::flag_bits_t flags
);

	// Sign of the result drives SF and both OF forms
	logic res_sign;

	// OF when the operand sign flips through the operation
	logic of_sign_change;

	// OF as carry into the MSB xor carry out of the MSB
	logic of_carry_xor;

	assign res_sign = result[31];

	assign of_sign_change = a_sign ^ res_sign;

	// Carry into bit 31 is a ^ b ^ r at the MSB, b sign is 0 for INC
	assign of_carry_xor = carry ^ a_sign ^ res_sign;

	// --------------------
	// Flag assembly
	// --------------------

	always_comb begin
		// of_sel high picks the sign-change form
		flags.of = of_sel ? of_sign_change : of_carry_xor;

		// Direction flag never set by these units
		flags.df = 1'b0;

		flags.sf = res_sign;
		flags.zf = (result == '0);

		// Auxiliary carry supplied by the unit
		flags.af = aux;

		// Even parity over the low byte only
		flags.pf = ~^result[7:0];

		// CF suppressed for INC, decode mask keeps the old value
		flags.cf = carry_en & carry;
	end

endmodule

// File: source/inc_by_1_w_flags.sv
// Increment by one with status flags
// Nibble carry chain gives the sum, the carry out and the AF carry from bit 3

`timescale 1ns/1ns

module inc_by_1_w_flags (
	input  x86_exec_pkg::word_t      a,
	output x86_exec_pkg::word_t      sum,
	output logic                     carry_out,
	output x86_exec_pkg::flag_bits_t flags
);

	// Carry out of each 4-bit group
	logic [7:0] nib_cout;

	// Ripple across nibbles, carry in of nibble 0 is the +1
	always_comb begin
		logic chain;
		chain = 1'b1;
		for (int i = 0; i < 8; i++) begin
			{nib_cout[i], sum[4*i +: 4]} = {1'b0, a[4*i +: 4]} + {4'b0000, chain};
			chain = nib_cout[i];
		end
	end

	// Carry out of bit 31, set only for all-ones input
	assign carry_out = nib_cout[7];

	// OF via carry xor, CF held at 0 for INC
	flag_logic flag_logic_inst (
		.result   (sum),
		.a_sign   (a[31]),
		.carry    (carry_out),
		.aux      (nib_cout[0]),
		.of_sel   (1'b0),
		.carry_en (1'b0),
		.flags    (flags)
	);

endmodule

// File: source/shift_arith_left_w_flags.sv
// Arithmetic shift left by a 5-bit count with status flags
// Last bit shifted out becomes CF, a zero count leaves a and gives CF 0

`timescale 1ns/1ns

module shift_arith_left_w_flags (
	input  x86_exec_pkg::word_t        a,
	input  x86_exec_pkg::shift_count_t count,
	output x86_exec_pkg::word_t        sal_result,
	output logic                       carry_out,
	output x86_exec_pkg::flag_bits_t   flags
);

	// --------------------
	// Shifter
	// --------------------

	// Extra bit above the MSB catches the last bit shifted out
	logic [32:0] shift_ext;

	assign shift_ext = {1'b0, a} << count;

	assign sal_result = shift_ext[31:0];

	// Bit 32 is a[32-n], and stays 0 when count is 0
	assign carry_out = shift_ext[32];

	// --------------------
	// Flags
	// --------------------

	// OF as sign change, only kept by decode for a count of 1
	// AF undefined after a shift, reported as 0
	flag_logic flag_logic_inst (
		.result   (sal_result),
		.a_sign   (a[31]),
		.carry    (carry_out),
		.aux      (1'b0),
		.of_sel   (1'b1),
		.carry_en (1'b1),
		.flags    (flags)
	);

endmodule

// File: source/shift_arith_right_w_flags.sv
// Arithmetic shift right by a 5-bit count with status flags
// Sign bit is replicated, the last bit shifted out becomes CF

`timescale 1ns/1ns

module shift_arith_right_w_flags (
	input  x86_exec_pkg::word_t        a,
	input  x86_exec_pkg::shift_count_t count,
	output x86_exec_pkg::word_t        sar_result,
	output logic                       carry_out,
	output x86_exec_pkg::flag_bits_t   flags
);

	// --------------------
	// Shifter
	// --------------------

	// Guard bit below the LSB catches the last bit shifted out
	logic signed [32:0] shift_ext;

	assign shift_ext = $signed({a, 1'b0}) >>> count;

	assign sar_result = shift_ext[32:1];

	// Guard bit is a[n-1], and stays 0 when count is 0
	assign carry_out = shift_ext[0];

	// --------------------
	// Flags
	// --------------------

	// Sign never changes under SAR so the sign-change OF is always 0
	// AF undefined after a shift, reported as 0
	flag_logic flag_logic_inst (
		.result   (sar_result),
		.a_sign   (a[31]),
		.carry    (carry_out),
		.aux      (1'b0),
		.of_sel   (1'b1),
		.carry_en (1'b1),
		.flags    (flags)
	);

endmodule

// File: source/x86_exec_pkg.sv
// Shared types for the execute-stage flag slice
// Data word, shift count, operation code, flag set and request/response structs
// Also the EFLAGS bit positions used when flags are packed into the 32-bit word

package x86_exec_pkg;

	// --------------------
	// Width types
	// --------------------

	// Operand, result and EFLAGS word
	typedef logic [31:0] word_t;

	// Masked shift count from the low bits of b
	typedef logic [4:0] shift_count_t;

	// --------------------
	// Operation select
	// --------------------

	typedef enum logic [1:0] {
		OP_INC = 2'd0,
		OP_SAL = 2'd1,
		OP_SAR = 2'd2
	} exec_op_t;

	// --------------------
	// Flag set
	// --------------------

	// Computed flags and the decode overwrite mask share this layout
	typedef struct packed {
		logic of;
		logic df;
		logic sf;
		logic zf;
		logic af;
		logic pf;
		logic cf;
	} flag_bits_t;

	// One request from decode, 73 bits
	typedef struct packed {
		exec_op_t   op;
		word_t      a;
		word_t      b;
		flag_bits_t flag_mask;
	} exec_req_t;

	// Registered result plus merged EFLAGS, 64 bits
	typedef struct packed {
		word_t result;
		word_t eflags;
	} exec_rsp_t;

	// --------------------
	// EFLAGS layout
	// --------------------

	localparam int unsigned CF_BIT = 0;
	localparam int unsigned PF_BIT = 2;
	localparam int unsigned AF_BIT = 4;
	localparam int unsigned ZF_BIT = 6;
	localparam int unsigned SF_BIT = 7;
	localparam int unsigned DF_BIT = 10;
	localparam int unsigned OF_BIT = 11;

	// Reserved bit that always reads 1
	localparam int unsigned EFLAGS_FIXED_ONE = 1;

endpackage
